// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [1:0]  fwd_sel_t;

	// Major opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_J     = 6'h02;
	localparam opcode_t OP_JAL   = 6'h03;
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_BNE   = 6'h05;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_ANDI  = 6'h0c;
	localparam opcode_t OP_ORI   = 6'h0d;
	localparam opcode_t OP_LUI   = 6'h0f;
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_SW    = 6'h2b;

	// Function field of register instructions
	localparam funct_t FN_SLL = 6'h00;
	localparam funct_t FN_JR  = 6'h08;
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR  = 6'h25;
	localparam funct_t FN_SLT = 6'h2a;

	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_AND = 4'd2;
	localparam alu_op_t ALU_OR  = 4'd3;
	localparam alu_op_t ALU_SLT = 4'd4;
	localparam alu_op_t ALU_SLL = 4'd5;
	localparam alu_op_t ALU_LUI = 4'd6;

	// Decode operand sources
	localparam fwd_sel_t FWD_REG = 2'd0;
	localparam fwd_sel_t FWD_EX  = 2'd1;
	localparam fwd_sel_t FWD_MEM = 2'd2;
	localparam fwd_sel_t FWD_WB  = 2'd3;

	// Stores with these address bits on top go to the output port
	localparam logic [5:0] IO_PREFIX = 6'b111111;

	typedef struct packed {
		logic    reg_write;
		logic    mem_to_reg;
		logic    mem_read;
		logic    mem_write;
		logic    branch_eq;
		logic    branch_ne;
		logic    jump;
		logic    jump_reg;
		logic    link;
		logic    reg_dst;
		logic    alu_imm;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     pc_next;
		word_t     rs_data;
		word_t     rt_data;
		word_t     imm;
		word_t     jump_target;
		reg_addr_t rs;
		reg_addr_t dst;
	} id_ex_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_to_reg;
		logic      mem_read;
		logic      mem_write;
		word_t     result;
		word_t     store_data;
		reg_addr_t dst;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		word_t     wdata;
		reg_addr_t dst;
	} mem_wb_t;

endpackage

`default_nettype wire

// File: design/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder import cpu_pkg::*; (
	input  word_t instr,
	output ctrl_t ctrl,
	output word_t imm
);

	opcode_t opcode;
	funct_t  funct;
	logic    zero_ext;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	always_comb begin
		ctrl = '0;
		case (opcode)
			OP_RTYPE: begin
				ctrl.reg_write = 1'b1;
				ctrl.reg_dst   = 1'b1;
				case (funct)
					FN_ADD: ctrl.alu_op = ALU_ADD;
					FN_SUB: ctrl.alu_op = ALU_SUB;
					FN_AND: ctrl.alu_op = ALU_AND;
					FN_OR:  ctrl.alu_op = ALU_OR;
					FN_SLT: ctrl.alu_op = ALU_SLT;
					FN_SLL: ctrl.alu_op = ALU_SLL;
					FN_JR: begin
						ctrl.reg_write = 1'b0;
						ctrl.reg_dst   = 1'b0;
						ctrl.jump_reg  = 1'b1;
					end
					default: ctrl = '0;
				endcase
			end
			OP_ADDI, OP_ANDI, OP_ORI, OP_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_imm   = 1'b1;
				case (opcode)
					OP_ANDI: ctrl.alu_op = ALU_AND;
					OP_ORI:  ctrl.alu_op = ALU_OR;
					OP_LUI:  ctrl.alu_op = ALU_LUI;
					default: ctrl.alu_op = ALU_ADD;
				endcase
			end
			OP_LW: begin
				ctrl.reg_write  = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.alu_imm    = 1'b1;
			end
			OP_SW: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_imm   = 1'b1;
			end
			OP_BEQ: ctrl.branch_eq = 1'b1;
			OP_BNE: ctrl.branch_ne = 1'b1;
			OP_J:   ctrl.jump = 1'b1;
			OP_JAL: begin
				ctrl.jump      = 1'b1;
				ctrl.link      = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

	// Logical immediates are zero extended
	assign zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI);
	assign imm = zero_ext ? {16'h0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
	input  alu_op_t   op,
	input  word_t     a,
	input  word_t     b,
	input  reg_addr_t shamt,
	output word_t     result,
	output logic      zero
);

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			// Signed compare
			ALU_SLT: result = {31'h0, $signed(a) < $signed(b)};
			// Shifts the rt operand, as MIPS does
			ALU_SLL: result = b << shamt;
			ALU_LUI: result = {b[15:0], 16'h0};
			default: result = '0;
		endcase
	end

	// Branch compare uses the raw operands, independent of op
	assign zero = (a == b);

endmodule

`default_nettype wire

// File: design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t rd_addr_a,
	input  reg_addr_t rd_addr_b,
	output word_t     rd_data_a,
	output word_t     rd_data_b,
	input  logic      wr_en,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data
);

	word_t regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Register zero is never written, so it stays zero after reset
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// File: design/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
	input  reg_addr_t rs,
	input  reg_addr_t rt,
	input  reg_addr_t ex_dst,
	input  reg_addr_t mem_dst,
	input  reg_addr_t wb_dst,
	input  logic      ex_write,
	input  logic      ex_load,
	input  logic      mem_write_reg,
	input  logic      wb_write,
	output fwd_sel_t  fwd_rs,
	output fwd_sel_t  fwd_rt,
	output logic      stall
);

	// Youngest producer wins
	function automatic fwd_sel_t pick(input reg_addr_t src);
		if (src == '0) begin
			return FWD_REG;
		end else if (ex_write && !ex_load && (ex_dst == src)) begin
			return FWD_EX;
		end else if (mem_write_reg && (mem_dst == src)) begin
			return FWD_MEM;
		end else if (wb_write && (wb_dst == src)) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	always_comb begin
		fwd_rs = pick(rs);
		fwd_rt = pick(rt);
	end

	// Load data is not ready until the memory stage
	assign stall = ex_load && (ex_dst != '0) && ((ex_dst == rs) || (ex_dst == rt));

endmodule

`default_nettype wire

// File: design/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory import cpu_pkg::*; #(
	parameter int DMEM_WORDS = 256
) (
	input  logic       clk,
	input  word_t      addr,
	input  word_t      wr_data,
	input  logic       rd_en,
	input  logic       wr_en,
	output word_t      rd_data,
	output logic       io_valid,
	output logic [7:0] io_addr,
	output word_t      io_data
);

	localparam int DA = $clog2(DMEM_WORDS);

	word_t          mem [DMEM_WORDS];
	logic [DA-1:0]  idx;
	logic           io_hit;

	assign idx    = addr[DA+1:2];
	assign io_hit = (addr[31:26] == IO_PREFIX);

	always_ff @(posedge clk) begin
		if (wr_en && !io_hit) begin
			mem[idx] <= wr_data;
		end
	end

	// Output region reads back as zero
	assign rd_data = (rd_en && !io_hit) ? mem[idx] : '0;

	////////////////////
	// Output port
	assign io_valid = wr_en && io_hit;
	assign io_addr  = addr[7:0];
	assign io_data  = wr_data;

endmodule

`default_nettype wire

// File: design/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       run,
	input  logic       prog_we,
	input  word_t      prog_addr,
	input  word_t      prog_data,
	output logic       io_valid,
	output logic [7:0] io_addr,
	output word_t      io_data
);

	localparam int IA = $clog2(IMEM_WORDS);

	word_t    imem [IMEM_WORDS];
	word_t    pc;
	word_t    pc_plus4;
	word_t    fetch_instr;
	word_t    if_id_instr;
	word_t    if_id_pc_next;
	ctrl_t    id_ctrl;
	word_t    id_imm;
	word_t    rf_rs;
	word_t    rf_rt;
	fwd_sel_t fwd_rs;
	fwd_sel_t fwd_rt;
	logic     stall;
	id_ex_t   id_ex_d;
	id_ex_t   id_ex_q;
	word_t    alu_b;
	word_t    alu_result;
	logic     alu_zero;
	word_t    ex_result;
	word_t    branch_target;
	logic     redirect;
	word_t    redirect_target;
	ex_mem_t  ex_mem_d;
	ex_mem_t  ex_mem_q;
	word_t    dmem_rd_data;
	word_t    mem_result;
	mem_wb_t  mem_wb_d;
	mem_wb_t  mem_wb_q;

	////////////////////
	// Fetch

	// prog_addr is a word index, not a byte address
	always_ff @(posedge clk) begin
		if (prog_we) begin
			imem[prog_addr[IA-1:0]] <= prog_data;
		end
	end

	assign fetch_instr = imem[pc[IA+1:2]];
	assign pc_plus4    = pc + 32'd4;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_target;
		end else if (run && !stall) begin
			pc <= pc_plus4;
		end
	end

	// Zero word is a nop, so a cleared register is a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_id_instr   <= '0;
			if_id_pc_next <= '0;
		end else if (redirect) begin
			if_id_instr   <= '0;
			if_id_pc_next <= '0;
		end else if (stall) begin
			if_id_instr   <= if_id_instr;
		end else if (!run) begin
			if_id_instr   <= '0;
			if_id_pc_next <= '0;
		end else begin
			if_id_instr   <= fetch_instr;
			if_id_pc_next <= pc_plus4;
		end
	end

	////////////////////
	// Decode

	decoder i_decoder (
		.instr (if_id_instr),
		.ctrl  (id_ctrl),
		.imm   (id_imm)
	);

	regfile i_regfile (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (if_id_instr[25:21]),
		.rd_addr_b (if_id_instr[20:16]),
		.rd_data_a (rf_rs),
		.rd_data_b (rf_rt),
		.wr_en     (mem_wb_q.reg_write),
		.wr_addr   (mem_wb_q.dst),
		.wr_data   (mem_wb_q.wdata)
	);

	hazard_unit i_hazard_unit (
		.rs            (if_id_instr[25:21]),
		.rt            (if_id_instr[20:16]),
		.ex_dst        (id_ex_q.dst),
		.mem_dst       (ex_mem_q.dst),
		.wb_dst        (mem_wb_q.dst),
		.ex_write      (id_ex_q.ctrl.reg_write),
		.ex_load       (id_ex_q.ctrl.mem_read),
		.mem_write_reg (ex_mem_q.reg_write),
		.wb_write      (mem_wb_q.reg_write),
		.fwd_rs        (fwd_rs),
		.fwd_rt        (fwd_rt),
		.stall         (stall)
	);

	function automatic word_t fwd_value(input fwd_sel_t sel, input word_t rf_data);
		case (sel)
			FWD_EX:  return ex_result;
			FWD_MEM: return mem_result;
			FWD_WB:  return mem_wb_q.wdata;
			default: return rf_data;
		endcase
	endfunction

	always_comb begin
		id_ex_d.ctrl        = id_ctrl;
		id_ex_d.pc_next     = if_id_pc_next;
		id_ex_d.rs_data     = fwd_value(fwd_rs, rf_rs);
		id_ex_d.rt_data     = fwd_value(fwd_rt, rf_rt);
		id_ex_d.imm         = id_imm;
		id_ex_d.jump_target = {if_id_pc_next[31:28], if_id_instr[25:0], 2'b00};
		id_ex_d.rs          = if_id_instr[25:21];
		// jal always links through r31
		if (id_ctrl.link) begin
			id_ex_d.dst = 5'd31;
		end else if (id_ctrl.reg_dst) begin
			id_ex_d.dst = if_id_instr[15:11];
		end else begin
			id_ex_d.dst = if_id_instr[20:16];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex_q <= '0;
		end else if (redirect || stall) begin
			id_ex_q <= '0;
		end else begin
			id_ex_q <= id_ex_d;
		end
	end

	////////////////////
	// Execute

	assign alu_b = id_ex_q.ctrl.alu_imm ? id_ex_q.imm : id_ex_q.rt_data;

	alu i_alu (
		.op     (id_ex_q.ctrl.alu_op),
		.a      (id_ex_q.rs_data),
		.b      (alu_b),
		.shamt  (id_ex_q.imm[10:6]),
		.result (alu_result),
		.zero   (alu_zero)
	);

	assign ex_result     = id_ex_q.ctrl.link ? id_ex_q.pc_next : alu_result;
	assign branch_target = id_ex_q.pc_next + {id_ex_q.imm[29:0], 2'b00};

	assign redirect = id_ex_q.ctrl.jump || id_ex_q.ctrl.jump_reg
		|| (id_ex_q.ctrl.branch_eq && alu_zero)
		|| (id_ex_q.ctrl.branch_ne && !alu_zero);

	always_comb begin
		if (id_ex_q.ctrl.jump_reg) begin
			redirect_target = id_ex_q.rs_data;
		end else if (id_ex_q.ctrl.jump) begin
			redirect_target = id_ex_q.jump_target;
		end else begin
			redirect_target = branch_target;
		end
	end

	always_comb begin
		ex_mem_d.reg_write  = id_ex_q.ctrl.reg_write;
		ex_mem_d.mem_to_reg = id_ex_q.ctrl.mem_to_reg;
		ex_mem_d.mem_read   = id_ex_q.ctrl.mem_read;
		ex_mem_d.mem_write  = id_ex_q.ctrl.mem_write;
		ex_mem_d.result     = ex_result;
		ex_mem_d.store_data = id_ex_q.rt_data;
		ex_mem_d.dst        = id_ex_q.dst;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem_q <= '0;
		end else begin
			ex_mem_q <= ex_mem_d;
		end
	end

	////////////////////
	// Memory

	data_memory #(
		.DMEM_WORDS (DMEM_WORDS)
	) i_data_memory (
		.clk      (clk),
		.addr     (ex_mem_q.result),
		.wr_data  (ex_mem_q.store_data),
		.rd_en    (ex_mem_q.mem_read),
		.wr_en    (ex_mem_q.mem_write),
		.rd_data  (dmem_rd_data),
		.io_valid (io_valid),
		.io_addr  (io_addr),
		.io_data  (io_data)
	);

	assign mem_result = ex_mem_q.mem_to_reg ? dmem_rd_data : ex_mem_q.result;

	always_comb begin
		mem_wb_d.reg_write = ex_mem_q.reg_write;
		mem_wb_d.wdata     = mem_result;
		mem_wb_d.dst       = ex_mem_q.dst;
	end

	// Write-back happens straight from this register into the regfile
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb_q <= '0;
		end else begin
			mem_wb_q <= mem_wb_d;
		end
	end

endmodule

`default_nettype wire

// File: tb/cpu_props.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_props import cpu_pkg::*; (
	input logic      clk,
	input logic      rst_n,
	input logic      io_valid,
	input logic      stall,
	input logic      redirect,
	input word_t     redirect_target,
	input word_t     pc,
	input reg_addr_t rs_addr,
	input reg_addr_t rt_addr,
	input word_t     rs_data,
	input word_t     rt_data
);

	// Count of failed assertions
	int fail_count;

	initial fail_count = 0;

	io_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(io_valid))
	else begin
		$error("io_valid is unknown after reset");
		fail_count++;
	end

	// A taken branch or jump in execute loads its target into the pc
	redirect_reaches_pc: assert property (@(posedge clk) disable iff (!rst_n)
		redirect |=> (pc == $past(redirect_target)))
	else begin
		$error("redirect in execute did not load its target into the pc");
		fail_count++;
	end

	stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(pc))
	else begin
		$error("pc moved during a stall");
		fail_count++;
	end

	////////////////////
	// Register zero

	zero_reads_zero_a: assert property (@(posedge clk) disable iff (!rst_n)
		(rs_addr == '0) |-> (rs_data == '0))
	else begin
		$error("register zero read nonzero on port a");
		fail_count++;
	end

	zero_reads_zero_b: assert property (@(posedge clk) disable iff (!rst_n)
		(rt_addr == '0) |-> (rt_data == '0))
	else begin
		$error("register zero read nonzero on port b");
		fail_count++;
	end

endmodule

`default_nettype wire

// File: tb/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

	localparam int    CLK_PERIOD      = 20;
	localparam int    RESET_CYCLES    = 4;
	localparam int    IMEM_WORDS      = 256;
	localparam int    DMEM_WORDS      = 256;
	localparam int    CYCLES_PER_WORD = 40;
	localparam int    DRAIN_CYCLES    = 10;
	localparam string STIM_FILE       = "tb/cpu_stim.txt";

	logic       clk;
	logic       rst_n;
	logic       run;
	logic       prog_we;
	word_t      prog_addr;
	word_t      prog_data;
	logic       io_valid;
	logic [7:0] io_addr;
	word_t      io_data;

	word_t      prog_q[$];
	logic [7:0] exp_addr_q[$];
	word_t      exp_data_q[$];
	int         errors;
	int         missing;
	int         writes_seen;
	int         watchdog_cycles;
	logic       stim_ok;
	logic       stim_ready;
	logic       timed_out;

	cpu #(
		.IMEM_WORDS (IMEM_WORDS),
		.DMEM_WORDS (DMEM_WORDS)
	) i_cpu (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.io_valid  (io_valid),
		.io_addr   (io_addr),
		.io_data   (io_data)
	);

	bind cpu cpu_props i_cpu_props (
		.clk             (clk),
		.rst_n           (rst_n),
		.io_valid        (io_valid),
		.stall           (stall),
		.redirect        (redirect),
		.redirect_target (redirect_target),
		.pc              (pc),
		.rs_addr         (if_id_instr[25:21]),
		.rt_addr         (if_id_instr[20:16]),
		.rs_data         (rf_rs),
		.rt_data         (rf_rt)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2);
			clk = ~clk;
		end
	end

	////////////////////
	// Helpers

	// P lines are program words, E lines are expected port writes
	task automatic read_stim();
		int         fd;
		string      line;
		word_t      instr_word;
		logic [7:0] addr;
		word_t      data;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("could not open the stimulus file %s", STIM_FILE);
			stim_ok = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) != 0) begin
					if ($sscanf(line, "P %h", instr_word) == 1) begin
						prog_q.push_back(instr_word);
					end else if ($sscanf(line, "E %h %h", addr, data) == 2) begin
						exp_addr_q.push_back(addr);
						exp_data_q.push_back(data);
					end
				end
			end
			$fclose(fd);
			stim_ok = (prog_q.size() > 0) && (exp_addr_q.size() > 0);
			if (!stim_ok) begin
				$display("the stimulus file holds no program or no expected port writes");
			end
		end
	endtask

	// Word index addressing on the load port
	task automatic load_program();
		for (int i = 0; i < prog_q.size(); i++) begin
			@(negedge clk);
			prog_we   = 1'b1;
			prog_addr = word_t'(i);
			prog_data = prog_q[i];
		end
		@(negedge clk);
		prog_we = 1'b0;
	endtask

	task automatic check_port_write(input logic [7:0] addr, input word_t data);
		logic [7:0] exp_addr;
		word_t      exp_data;
		writes_seen++;
		if (exp_addr_q.size() == 0) begin
			$display("unexpected port write to address %h with data %h after the last one",
				addr, data);
			errors++;
		end else begin
			exp_addr = exp_addr_q.pop_front();
			exp_data = exp_data_q.pop_front();
			if ((addr !== exp_addr) || (data !== exp_data)) begin
				$display("error at %0d ns: port write %0d expected addr %h data %h, got addr %h data %h",
					$time, writes_seen, exp_addr, exp_data, addr, data);
				errors++;
			end
		end
	endtask

	task automatic finish_run();
		int total;
		total = errors + i_cpu.i_cpu_props.fail_count;
		$display("summary: errors %0d, missing writes %0d", total, missing);
		if ((total == 0) && (missing == 0) && !timed_out) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	////////////////////
	// Port monitor

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		if (rst_n && io_valid) begin
			check_port_write(io_addr, io_data);
		end
	end

	initial begin
		wait (stim_ready);
		repeat (watchdog_cycles) @(posedge clk);
		timed_out = 1'b1;
		missing   = exp_addr_q.size();
		$display("timeout after %0d cycles: the expected port writes did not all arrive",
			watchdog_cycles);
		finish_run();
	end

	initial begin
		rst_n           = 1'b0;
		run             = 1'b0;
		prog_we         = 1'b0;
		prog_addr       = '0;
		prog_data       = '0;
		errors          = 0;
		missing         = 0;
		writes_seen     = 0;
		watchdog_cycles = 0;
		stim_ok         = 1'b0;
		stim_ready      = 1'b0;
		timed_out       = 1'b0;
		read_stim();
		if (stim_ok) begin
			watchdog_cycles = RESET_CYCLES + DRAIN_CYCLES
				+ prog_q.size() * (CYCLES_PER_WORD + 1);
			stim_ready = 1'b1;
		end else begin
			errors++;
		end
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		if (stim_ok) begin
			load_program();
			@(negedge clk);
			run = 1'b1;
			while (exp_addr_q.size() != 0) begin
				@(negedge clk);
			end
			// Catch stray writes from the halt loop
			repeat (DRAIN_CYCLES) @(negedge clk);
		end
		missing = exp_addr_q.size();
		finish_run();
	end

endmodule

`default_nettype wire

// File: tb/cpu_stim.txt
# P <instruction word hex>           program word, loaded at word 0 upward
# E <port addr hex> <data hex>       expected output port write, in arrival order
P 3C01FC00  # 00 lui  $1, 0xfc00      output region base
P 20020005  # 01 addi $2, $0, 5
P 2043FFFD  # 02 addi $3, $2, -3
P 00432020  # 03 add  $4, $2, $3
P 00822822  # 04 sub  $5, $4, $2
P AC240000  # 05 sw   $4, 0x00($1)
P AC250004  # 06 sw   $5, 0x04($1)
P 3406F0F0  # 07 ori  $6, $0, 0xf0f0
P 30C70FF0  # 08 andi $7, $6, 0x0ff0
P 00C44025  # 09 or   $8, $6, $4
P 01074824  # 10 and  $9, $8, $7
P 0062502A  # 11 slt  $10, $3, $2
P 00085900  # 12 sll  $11, $8, 4
P AC280008  # 13 sw   $8, 0x08($1)
P AC29000C  # 14 sw   $9, 0x0c($1)
P AC2A0010  # 15 sw   $10, 0x10($1)
P AC2B0014  # 16 sw   $11, 0x14($1)
P AC040040  # 17 sw   $4, 0x40($0)
P 8C0C0040  # 18 lw   $12, 0x40($0)
P 018C6820  # 19 add  $13, $12, $12   load-use stall
P AC2D0018  # 20 sw   $13, 0x18($1)
P 10840002  # 21 beq  $4, $4, +2      taken
P AC22001C  # 22 sw   $2, 0x1c($1)    flushed
P AC230020  # 23 sw   $3, 0x20($1)    flushed
P 14420002  # 24 bne  $2, $2, +2      not taken
P AC230024  # 25 sw   $3, 0x24($1)
P AC260028  # 26 sw   $6, 0x28($1)
P 0C00001F  # 27 jal  31
P 20000055  # 28 addi $0, $0, 0x55
P AC200034  # 29 sw   $0, 0x34($1)
P 0800001E  # 30 j    30              halt
P AC3F002C  # 31 sw   $31, 0x2c($1)
P 03E00008  # 32 jr   $31
E 00 00000007
E 04 00000002
E 08 0000F0F7
E 0C 000000F0
E 10 00000001
E 14 000F0F70
E 18 0000000E
E 24 00000002
E 28 0000F0F0
E 2C 00000070
E 34 00000000

// File: tb.f
design/cpu_pkg.sv
design/decoder.sv
design/alu.sv
design/regfile.sv
design/hazard_unit.sv
design/data_memory.sv
design/cpu.sv
tb/cpu_props.sv
tb/cpu_tb.sv

// File: Makefile
# Verilator build and run of the CPU testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
